// ==== csr_pkg.sv ====
package csr_pkg;

	// Machine-mode CSR addresses.
	localparam logic [11:0] addr_mstatus = 12'h300;
	localparam logic [11:0] addr_mie = 12'h304;
	localparam logic [11:0] addr_mtvec = 12'h305;
	localparam logic [11:0] addr_mscratch = 12'h340;
	localparam logic [11:0] addr_mepc = 12'h341;
	localparam logic [11:0] addr_mcause = 12'h342;
	localparam logic [11:0] addr_mip = 12'h344;

	// User-level counters, read only.
	localparam logic [11:0] addr_cycle = 12'hc00;
	localparam logic [11:0] addr_time = 12'hc01;
	localparam logic [11:0] addr_instret = 12'hc02;
	localparam logic [11:0] addr_cycleh = 12'hc80;
	localparam logic [11:0] addr_timeh = 12'hc81;
	localparam logic [11:0] addr_instreth = 12'hc82;

	// Machine information registers.
	localparam logic [11:0] addr_mvendorid = 12'hf11;
	localparam logic [11:0] addr_marchid = 12'hf12;
	localparam logic [11:0] addr_mimpid = 12'hf13;
	localparam logic [11:0] addr_mhartid = 12'hf14;

	// Trap causes as written to mcause.
	localparam logic [31:0] cause_machine_external = 32'h8000_000b;
	localparam logic [31:0] cause_machine_timer = 32'h8000_0007;
	localparam logic [31:0] cause_environment_call = 32'h0000_000b;

	typedef logic [11:0] csr_index_t;

	typedef enum logic [2:0] {
		op_none,
		op_write,
		op_set,
		op_clear,
		op_ecall,
		op_mret
	} csr_op_t;

	typedef struct packed {
		logic valid;
		csr_op_t op;
		csr_index_t index;
		logic [31:0] operand;
		logic write_enable;
		logic [4:0] rd;
		logic illegal;
	} csr_request_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] value;
		logic illegal;
	} csr_result_t;

endpackage

// ==== csr_decode.sv ====
module csr_decode (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instruction,
	input logic [31:0] i_rs1_value,
	output csr_pkg::csr_request_t o_request
);
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
	localparam logic [31:0] INSN_ECALL = 32'h0000_0073;
	localparam logic [31:0] INSN_MRET = 32'h3020_0073;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] rs1_field;
	csr_pkg::csr_request_t request;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign rs1_field = i_instruction[19:15];

	always_comb begin
		request = '0;
		request.valid = i_valid;
		request.op = csr_pkg::op_none;
		request.index = i_instruction[31:20];
		request.rd = i_instruction[11:7];
		// Immediate forms carry a zero-extended uimm in the rs1 field.
		request.operand = funct3[2] ? {27'b0, rs1_field} : i_rs1_value;

		if (opcode != OPCODE_SYSTEM) begin
			request.illegal = 1'b1;
		end
		else begin
			case (funct3)
				3'b000: begin
					if (i_instruction == INSN_ECALL)
						request.op = csr_pkg::op_ecall;
					else if (i_instruction == INSN_MRET)
						request.op = csr_pkg::op_mret;
					else
						request.illegal = 1'b1;
				end
				3'b001, 3'b101: begin
					request.op = csr_pkg::op_write;
					request.write_enable = 1'b1;
				end
				3'b010, 3'b110: begin
					// A zero source only reads, no side effects.
					request.op = csr_pkg::op_set;
					request.write_enable = (rs1_field != 5'd0);
				end
				3'b011, 3'b111: begin
					request.op = csr_pkg::op_clear;
					request.write_enable = (rs1_field != 5'd0);
				end
				default: request.illegal = 1'b1;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		o_request <= request;
		if (i_reset)
			o_request.valid <= 1'b0;
	end

endmodule

// ==== csr_file.sv ====
module csr_file #(
	parameter int FREQUENCY = 1000,
	parameter logic [31:0] VENDORID = 32'h0,
	parameter logic [31:0] ARCHID = 32'h0,
	parameter logic [31:0] IMPID = 32'h0,
	parameter logic [31:0] HARTID = 32'h0
) (
	input logic i_clock,
	input logic i_reset,
	input csr_pkg::csr_request_t i_request,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	input logic [63:0] i_retired,
	output csr_pkg::csr_result_t o_result,
	output logic [31:0] o_epc,
	output logic o_irq_pending,
	output logic [31:0] o_irq_pc,
	output logic o_external_interrupt_enable
);
	localparam int PRESCALE = FREQUENCY / 1000;
	localparam int PRESCALE_WIDTH = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

	logic mstatus_mie, mstatus_mpie;
	logic mie_meie, mie_mtie, mie_msie;
	logic mip_meip, mip_mtip, mip_msip;
	logic [31:0] mtvec, mscratch, mepc, mcause;
	logic issued_external, issued_timer, issued_software;
	logic [63:0] cycle, wall_time;
	logic [PRESCALE_WIDTH-1:0] prescale;

	logic [31:0] mstatus, mie, mip;
	logic [31:0] read_value, write_value;
	logic known, access, do_write, is_ecall, is_mret;
	csr_pkg::csr_result_t result;

	assign mstatus = {24'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
	assign mie = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
	assign mip = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};

	assign o_epc = mepc;
	assign o_external_interrupt_enable = !o_irq_pending && mstatus_mie && mie_meie;

	assign access = (i_request.op == csr_pkg::op_write) || (i_request.op == csr_pkg::op_set)
		|| (i_request.op == csr_pkg::op_clear);
	assign do_write = i_request.valid && access && i_request.write_enable && !i_request.illegal;
	assign is_ecall = i_request.valid && (i_request.op == csr_pkg::op_ecall);
	assign is_mret = i_request.valid && (i_request.op == csr_pkg::op_mret);

	// Read side, by address.
	always_comb begin
		known = 1'b1;
		case (i_request.index)
			csr_pkg::addr_mstatus: read_value = mstatus;
			csr_pkg::addr_mie: read_value = mie;
			csr_pkg::addr_mtvec: read_value = mtvec;
			csr_pkg::addr_mscratch: read_value = mscratch;
			csr_pkg::addr_mepc: read_value = mepc;
			csr_pkg::addr_mcause: read_value = mcause;
			csr_pkg::addr_mip: read_value = mip;
			csr_pkg::addr_cycle: read_value = cycle[31:0];
			csr_pkg::addr_cycleh: read_value = cycle[63:32];
			csr_pkg::addr_time: read_value = wall_time[31:0];
			csr_pkg::addr_timeh: read_value = wall_time[63:32];
			csr_pkg::addr_instret: read_value = i_retired[31:0];
			csr_pkg::addr_instreth: read_value = i_retired[63:32];
			csr_pkg::addr_mvendorid: read_value = VENDORID;
			csr_pkg::addr_marchid: read_value = ARCHID;
			csr_pkg::addr_mimpid: read_value = IMPID;
			csr_pkg::addr_mhartid: read_value = HARTID;
			default: begin
				read_value = 32'h0;
				known = 1'b0;
			end
		endcase
	end

	// Read-modify-write value.
	always_comb begin
		case (i_request.op)
			csr_pkg::op_set: write_value = read_value | i_request.operand;
			csr_pkg::op_clear: write_value = read_value & ~i_request.operand;
			default: write_value = i_request.operand;
		endcase
	end

	always_comb begin
		result.valid = i_request.valid;
		result.rd = i_request.rd;
		result.value = access ? read_value : 32'h0;
		result.illegal = i_request.illegal || (access && !known);
	end

	always_ff @(posedge i_clock) begin
		o_result <= result;
		if (i_reset)
			o_result.valid <= 1'b0;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_msie <= 1'b0;
			mip_meip <= 1'b0;
			mip_mtip <= 1'b0;
			mip_msip <= 1'b0;
			mtvec <= 32'h0;
			mscratch <= 32'h0;
			mepc <= 32'h0;
			mcause <= 32'h0;
			issued_external <= 1'b0;
			issued_timer <= 1'b0;
			issued_software <= 1'b0;
			o_irq_pending <= 1'b0;
		end
		else begin
			if (do_write) begin
				case (i_request.index)
					csr_pkg::addr_mstatus: begin
						mstatus_mie <= write_value[3];
						mstatus_mpie <= write_value[7];
					end
					csr_pkg::addr_mie: begin
						mie_meie <= write_value[11];
						mie_mtie <= write_value[7];
						mie_msie <= write_value[3];
					end
					csr_pkg::addr_mtvec: mtvec <= write_value;
					csr_pkg::addr_mscratch: mscratch <= write_value;
					csr_pkg::addr_mepc: mepc <= write_value;
					csr_pkg::addr_mcause: mcause <= write_value;
					// Only the timer bit is software clearable.
					csr_pkg::addr_mip: mip_mtip <= write_value[7];
					default: ;
				endcase
			end

			// Latch enabled interrupt sources.
			if (i_timer_interrupt && mie_mtie)
				mip_mtip <= 1'b1;
			if (i_external_interrupt && mie_meie)
				mip_meip <= 1'b1;
			if (is_ecall && mie_msie)
				mip_msip <= 1'b1;

			// Issue the highest priority pending source.
			if (!o_irq_pending && mstatus_mie && (mip_meip || mip_mtip || mip_msip)) begin
				if (mip_meip) begin
					mcause <= csr_pkg::cause_machine_external;
					issued_external <= 1'b1;
				end
				else if (mip_mtip) begin
					mcause <= csr_pkg::cause_machine_timer;
					issued_timer <= 1'b1;
				end
				else begin
					mcause <= csr_pkg::cause_environment_call;
					issued_software <= 1'b1;
				end
				o_irq_pending <= 1'b1;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end

			if (is_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b0;
			end

			// Core has taken the trap; clear the issued source.
			if (i_irq_dispatched) begin
				mepc <= i_irq_epc;
				if (issued_external)
					mip_meip <= 1'b0;
				if (issued_timer)
					mip_mtip <= 1'b0;
				if (issued_software)
					mip_msip <= 1'b0;
				issued_external <= 1'b0;
				issued_timer <= 1'b0;
				issued_software <= 1'b0;
				o_irq_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_irq_pending)
			o_irq_pc <= mtvec;
	end

	// Free-running cycle count, prescaled wall time.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycle <= 64'd0;
			wall_time <= 64'd0;
			prescale <= '0;
		end
		else begin
			cycle <= cycle + 64'd1;
			if (prescale == PRESCALE_WIDTH'(PRESCALE)) begin
				prescale <= '0;
				wall_time <= wall_time + 64'd1;
			end
			else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

endmodule

// ==== csr_retire.sv ====
module csr_retire (
	input logic i_clock,
	input logic i_reset,
	input csr_pkg::csr_result_t i_result,
	output csr_pkg::csr_result_t o_writeback,
	output logic [63:0] o_retired
);
	csr_pkg::csr_result_t writeback;

	// Illegal instructions never write a register.
	always_comb begin
		writeback = i_result;
		if (i_result.illegal)
			writeback.rd = 5'd0;
	end

	always_ff @(posedge i_clock) begin
		o_writeback <= writeback;
		if (i_reset)
			o_writeback.valid <= 1'b0;
	end

	// Every valid result counts, legal or not.
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_retired <= 64'd0;
		else if (i_result.valid)
			o_retired <= o_retired + 64'd1;
	end

endmodule

// ==== csr_top.sv ====
module csr_top #(
	parameter int FREQUENCY = 1000,
	parameter logic [31:0] VENDORID = 32'h0,
	parameter logic [31:0] ARCHID = 32'h0,
	parameter logic [31:0] IMPID = 32'h0,
	parameter logic [31:0] HARTID = 32'h0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [31:0] i_instruction,
	input logic [31:0] i_rs1_value,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	output csr_pkg::csr_result_t o_writeback,
	output logic o_irq_pending,
	output logic [31:0] o_irq_pc,
	output logic [31:0] o_epc,
	output logic o_external_interrupt_enable
);
	csr_pkg::csr_request_t request;
	csr_pkg::csr_result_t result;
	logic [63:0] retired;

	csr_decode i_csr_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_instruction(i_instruction),
		.i_rs1_value(i_rs1_value),
		.o_request(request)
	);

	csr_file #(
		.FREQUENCY(FREQUENCY),
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) i_csr_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(request),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.i_retired(retired),
		.o_result(result),
		.o_epc(o_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_external_interrupt_enable(o_external_interrupt_enable)
	);

	// Retire feeds its count back for instret reads.
	csr_retire i_csr_retire (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_result(result),
		.o_writeback(o_writeback),
		.o_retired(retired)
	);

endmodule

// ==== csr_checker.sv ====
module csr_checker (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic i_irq_dispatched,
	input csr_pkg::csr_result_t i_writeback,
	input logic i_irq_pending
);
	timeunit 1ns;
	timeprecision 1ps;

	int latency_failures = 0;
	int reset_failures = 0;
	int dispatch_failures = 0;

	// Decode, execute and retire each add one register.
	writeback_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		i_writeback.valid == $past(i_valid, 3))
	else begin
		$error("writeback valid does not follow i_valid by three cycles");
		latency_failures++;
	end

	pending_reset: assert property (@(posedge i_clock) i_reset |=> !i_irq_pending)
	else begin
		$error("irq pending is high after reset");
		reset_failures++;
	end

	// Pending clears on the edge that sees the dispatch strobe.
	pending_dispatch: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |=> !i_irq_pending)
	else begin
		$error("irq pending did not fall after dispatch");
		dispatch_failures++;
	end

endmodule

bind csr_top csr_checker i_csr_checker (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_valid(i_valid),
	.i_irq_dispatched(i_irq_dispatched),
	.i_writeback(o_writeback),
	.i_irq_pending(o_irq_pending)
);

// ==== tb_csr_top.sv ====
module tb_csr_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] VENDORID = 32'h0000_0489;
	localparam logic [31:0] ARCHID = 32'h0000_0017;
	localparam logic [31:0] IMPID = 32'h0001_0203;
	localparam logic [31:0] HARTID = 32'h0000_0000;
	localparam int TIMEOUT = 40;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;
	localparam logic [31:0] MRET = 32'h3020_0073;

	logic i_clock;
	logic i_reset;
	logic i_valid;
	logic [31:0] i_instruction;
	logic [31:0] i_rs1_value;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_irq_dispatched;
	logic [31:0] i_irq_epc;
	csr_pkg::csr_result_t o_writeback;
	logic o_irq_pending;
	logic [31:0] o_irq_pc;
	logic [31:0] o_epc;
	logic o_external_interrupt_enable;

	int checks;
	int errors;
	int issued;
	int test_start;
	int assertion_failures;
	string test_name;
	logic [31:0] mtvec_value;
	logic [31:0] scratch_value;
	logic [31:0] burst_instruction [4];
	csr_pkg::csr_result_t burst_result [4];
	csr_pkg::csr_result_t writebacks [$];

	csr_top #(
		.FREQUENCY(4000),
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) i_csr_top (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_instruction(i_instruction),
		.i_rs1_value(i_rs1_value),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_writeback(o_writeback),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_epc(o_epc),
		.o_external_interrupt_enable(o_external_interrupt_enable)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	// Writebacks are collected mid-cycle, away from the rising edge.
	always @(negedge i_clock) begin
		if (o_writeback.valid)
			writebacks.push_back(o_writeback);
	end

	task automatic step();
		@(posedge i_clock);
		#2;
	endtask

	function automatic logic [31:0] csr_instruction(input logic [2:0] funct3,
			input csr_pkg::csr_index_t index, input logic [4:0] source, input logic [4:0] rd);
		return {index, source, funct3, rd, 7'b1110011};
	endfunction

	function automatic csr_pkg::csr_result_t legal_result(input logic [4:0] rd,
			input logic [31:0] value);
		csr_pkg::csr_result_t result;
		result.valid = 1'b1;
		result.rd = rd;
		result.value = value;
		result.illegal = 1'b0;
		return result;
	endfunction

	task automatic compare_result(input csr_pkg::csr_result_t expected,
			input csr_pkg::csr_result_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch in %s: expected v%0b rd%0d %h ill%0b, actual v%0b rd%0d %h ill%0b",
				test_name, expected.valid, expected.rd, expected.value, expected.illegal,
				actual.valid, actual.rd, actual.value, actual.illegal);
		end
	endtask

	task automatic compare_word(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch in %s (%s): expected %h, actual %h", test_name, what,
				expected, actual);
		end
	endtask

	task automatic compare_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch in %s (%s): expected %0b, actual %0b", test_name, what,
				expected, actual);
		end
	endtask

	task automatic collect_writeback(output csr_pkg::csr_result_t result);
		int waited;
		waited = 0;
		while (writebacks.size() == 0 && waited < TIMEOUT) begin
			step();
			waited++;
		end
		if (writebacks.size() == 0) begin
			errors++;
			$display("%s: no writeback arrived within %0d cycles", test_name, TIMEOUT);
			result = '0;
		end
		else begin
			result = writebacks.pop_front();
		end
	endtask

	task automatic run_instruction(input logic [31:0] instruction, input logic [31:0] rs1_value,
			output csr_pkg::csr_result_t result);
		writebacks.delete();
		step();
		i_valid = 1'b1;
		i_instruction = instruction;
		i_rs1_value = rs1_value;
		step();
		i_valid = 1'b0;
		issued++;
		collect_writeback(result);
	endtask

	// Four instructions on consecutive cycles.
	task automatic run_burst();
		writebacks.delete();
		step();
		for (int n = 0; n < 4; n++) begin
			i_valid = 1'b1;
			i_instruction = burst_instruction[n];
			i_rs1_value = 32'h0;
			step();
		end
		i_valid = 1'b0;
		issued += 4;
		for (int n = 0; n < 4; n++)
			collect_writeback(burst_result[n]);
	endtask

	task automatic check_read(input csr_pkg::csr_index_t index, input logic [31:0] expected);
		csr_pkg::csr_result_t result;
		run_instruction(csr_instruction(F3_CSRRS, index, 5'd0, 5'd10), 32'h0, result);
		compare_result(legal_result(5'd10, expected), result);
	endtask

	task automatic read_csr(input csr_pkg::csr_index_t index, output logic [31:0] value);
		csr_pkg::csr_result_t result;
		run_instruction(csr_instruction(F3_CSRRS, index, 5'd0, 5'd10), 32'h0, result);
		compare_bit("read legal", 1'b0, result.illegal);
		value = result.value;
	endtask

	task automatic set_bits(input csr_pkg::csr_index_t index, input logic [31:0] mask);
		csr_pkg::csr_result_t result;
		run_instruction(csr_instruction(F3_CSRRS, index, 5'd7, 5'd9), mask, result);
		compare_bit("set legal", 1'b0, result.illegal);
	endtask

	task automatic run_mret();
		csr_pkg::csr_result_t result;
		run_instruction(MRET, 32'h0, result);
		compare_bit("mret legal", 1'b0, result.illegal);
	endtask

	task automatic wait_pending(input logic level);
		int waited;
		waited = 0;
		while (o_irq_pending !== level && waited < TIMEOUT) begin
			step();
			waited++;
		end
		checks++;
		if (o_irq_pending !== level) begin
			errors++;
			$display("%s: o_irq_pending did not reach %0b within %0d cycles", test_name,
				level, TIMEOUT);
		end
	endtask

	task automatic pulse_interrupts(input logic timer, input logic external);
		step();
		i_timer_interrupt = timer;
		i_external_interrupt = external;
		step();
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
	endtask

	task automatic dispatch(input logic [31:0] epc);
		step();
		i_irq_dispatched = 1'b1;
		i_irq_epc = epc;
		step();
		i_irq_dispatched = 1'b0;
		compare_bit("pending after dispatch", 1'b0, o_irq_pending);
		compare_word("epc", epc, o_epc);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start = errors;
	endtask

	task automatic end_test();
		$display("%s: done, %0d errors", test_name, errors - test_start);
	endtask

	task automatic check_write_read(input csr_pkg::csr_index_t index, input logic [31:0] word);
		csr_pkg::csr_result_t result;
		run_instruction(csr_instruction(F3_CSRRW, index, 5'd5, 5'd1), word, result);
		compare_result(legal_result(5'd1, 32'h0), result);
		check_read(index, word);
	endtask

	task automatic test_read_write();
		begin_test("read_write");
		scratch_value = $urandom;
		mtvec_value = $urandom;
		check_write_read(csr_pkg::addr_mscratch, scratch_value);
		check_write_read(csr_pkg::addr_mtvec, mtvec_value);
		check_write_read(csr_pkg::addr_mepc, $urandom);
		end_test();
	endtask

	task automatic test_set_clear();
		csr_pkg::csr_result_t result;
		logic [31:0] mask;
		logic [31:0] model;
		logic [4:0] uimm;
		begin_test("set_clear");
		model = scratch_value;
		repeat (4) begin
			mask = $urandom;
			run_instruction(csr_instruction(F3_CSRRS, csr_pkg::addr_mscratch, 5'd6, 5'd12),
				mask, result);
			compare_result(legal_result(5'd12, model), result);
			model = model | mask;
			mask = $urandom;
			run_instruction(csr_instruction(F3_CSRRC, csr_pkg::addr_mscratch, 5'd6, 5'd12),
				mask, result);
			compare_result(legal_result(5'd12, model), result);
			model = model & ~mask;
		end
		// Immediate forms, with an rs1 value that must be ignored.
		uimm = 5'(($urandom % 31) + 1);
		run_instruction(csr_instruction(F3_CSRRSI, csr_pkg::addr_mscratch, uimm, 5'd13),
			32'hffff_ffff, result);
		compare_result(legal_result(5'd13, model), result);
		model = model | {27'b0, uimm};
		uimm = 5'(($urandom % 31) + 1);
		run_instruction(csr_instruction(F3_CSRRCI, csr_pkg::addr_mscratch, uimm, 5'd13),
			32'hffff_ffff, result);
		compare_result(legal_result(5'd13, model), result);
		model = model & ~{27'b0, uimm};
		check_read(csr_pkg::addr_mscratch, model);
		scratch_value = model;
		end_test();
	endtask

	task automatic check_read_only(input csr_pkg::csr_index_t index, input logic [31:0] value);
		csr_pkg::csr_result_t result;
		check_read(index, value);
		run_instruction(csr_instruction(F3_CSRRW, index, 5'd5, 5'd14), $urandom, result);
		compare_result(legal_result(5'd14, value), result);
		check_read(index, value);
	endtask

	task automatic test_read_only_illegal();
		csr_pkg::csr_result_t result;
		csr_pkg::csr_result_t illegal;
		begin_test("read_only_illegal");
		check_read_only(csr_pkg::addr_mvendorid, VENDORID);
		check_read_only(csr_pkg::addr_marchid, ARCHID);
		check_read_only(csr_pkg::addr_mimpid, IMPID);
		check_read_only(csr_pkg::addr_mhartid, HARTID);
		illegal = '0;
		illegal.valid = 1'b1;
		illegal.illegal = 1'b1;
		run_instruction(csr_instruction(F3_CSRRW, 12'h7c0, 5'd5, 5'd15), $urandom, result);
		compare_result(illegal, result);
		run_instruction(csr_instruction(3'b100, csr_pkg::addr_mscratch, 5'd5, 5'd16),
			$urandom, result);
		compare_result(illegal, result);
		check_read(csr_pkg::addr_mscratch, scratch_value);
		end_test();
	endtask

	task automatic test_timer_interrupt();
		logic [31:0] value;
		begin_test("timer_interrupt");
		set_bits(csr_pkg::addr_mie, 32'h0000_0080);
		set_bits(csr_pkg::addr_mstatus, 32'h0000_0008);
		pulse_interrupts(1'b1, 1'b0);
		wait_pending(1'b1);
		compare_word("irq pc", mtvec_value, o_irq_pc);
		dispatch($urandom);
		check_read(csr_pkg::addr_mcause, csr_pkg::cause_machine_timer);
		read_csr(csr_pkg::addr_mstatus, value);
		compare_bit("mstatus.MIE in trap", 1'b0, value[3]);
		compare_bit("mstatus.MPIE in trap", 1'b1, value[7]);
		run_mret();
		read_csr(csr_pkg::addr_mstatus, value);
		compare_bit("mstatus.MIE after mret", 1'b1, value[3]);
		end_test();
	endtask

	task automatic test_priority();
		begin_test("priority");
		set_bits(csr_pkg::addr_mie, 32'h0000_0800);
		compare_bit("external enable idle", 1'b1, o_external_interrupt_enable);
		pulse_interrupts(1'b1, 1'b1);
		wait_pending(1'b1);
		compare_bit("external enable pending", 1'b0, o_external_interrupt_enable);
		check_read(csr_pkg::addr_mcause, csr_pkg::cause_machine_external);
		dispatch($urandom);
		run_mret();
		// The timer source is still latched and issues next.
		wait_pending(1'b1);
		compare_bit("external enable pending", 1'b0, o_external_interrupt_enable);
		check_read(csr_pkg::addr_mcause, csr_pkg::cause_machine_timer);
		dispatch($urandom);
		run_mret();
		compare_bit("external enable after return", 1'b1, o_external_interrupt_enable);
		end_test();
	endtask

	task automatic test_counters();
		logic [31:0] first;
		logic [31:0] previous;
		logic [31:0] current;
		int expected_instret;
		begin_test("counters");
		burst_instruction[0] = csr_instruction(F3_CSRRS, csr_pkg::addr_cycle, 5'd0, 5'd1);
		burst_instruction[1] = csr_instruction(F3_CSRRS, csr_pkg::addr_mscratch, 5'd0, 5'd2);
		burst_instruction[2] = csr_instruction(F3_CSRRS, csr_pkg::addr_mscratch, 5'd0, 5'd3);
		burst_instruction[3] = csr_instruction(F3_CSRRS, csr_pkg::addr_cycle, 5'd0, 5'd4);
		run_burst();
		compare_result(legal_result(5'd2, scratch_value), burst_result[1]);
		compare_result(legal_result(5'd3, scratch_value), burst_result[2]);
		compare_word("cycle distance", 32'd3, burst_result[3].value - burst_result[0].value);
		read_csr(csr_pkg::addr_time, first);
		previous = first;
		current = first;
		repeat (4) begin
			repeat (3) step();
			read_csr(csr_pkg::addr_time, current);
			compare_bit("time monotonic", 1'b1, current >= previous);
			previous = current;
		end
		compare_bit("time advanced", 1'b1, current > first);
		repeat (6) check_read(csr_pkg::addr_mscratch, scratch_value);
		expected_instret = issued;
		read_csr(csr_pkg::addr_instret, current);
		compare_word("instret", 32'(expected_instret), current);
		end_test();
	endtask

	initial begin
		void'($urandom(92895));
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_instruction = 32'h0;
		i_rs1_value = 32'h0;
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = 32'h0;
		checks = 0;
		errors = 0;
		issued = 0;
		repeat (8) @(posedge i_clock);
		#2;
		i_reset = 1'b0;

		test_read_write();
		test_set_clear();
		test_read_only_illegal();
		test_timer_interrupt();
		test_priority();
		test_counters();

		assertion_failures = i_csr_top.i_csr_checker.latency_failures
			+ i_csr_top.i_csr_checker.reset_failures
			+ i_csr_top.i_csr_checker.dispatch_failures;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			assertion_failures);
		if (errors == 0 && assertion_failures == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
csr_pkg.sv
csr_decode.sv
csr_file.sv
csr_retire.sv
csr_top.sv
csr_checker.sv
tb_csr_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_csr_top

./obj_dir/Vtb_csr_top +verilator+error+limit+100 | tee sim.log

grep -q "TESTBENCH PASSED" sim.log
echo "simulation passed"
